//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = glueTb
FILELIST = project.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- design/busDecode.sv
`timescale 1ns/10ps

module busDecode import busPkg::*; (
	input  logic         CLK,
	input  logic         rst,
	input  logic         nAS,
	input  logic [23:22] A,
	output logic         bact,
	output logic         ramSel,
	output logic         romSel
);

	logic overlay;    // ROM also answers at address zero
	logic romTouched; // Current cycle hit the ROM window
	regionT region;

	always_ff @(posedge CLK) begin
		if (rst) begin
			bact <= 1'b0;
			overlay <= 1'b1;
			romTouched <= 1'b0;
		end else begin
			bact <= !nAS;
			if (!nAS && bact && A == RomWindow)
				romTouched <= 1'b1;
			// Overlay goes away once that cycle has ended
			if (romTouched && !bact)
				overlay <= 1'b0;
		end
	end

	// Region decode, only while the strobe is down
	always_comb begin
		region = regionNone;
		if (!nAS) begin
			case (A)
				RomWindow: region = regionRom;
				RamWindow: region = overlay ? regionRom : regionRam;
				default:   region = regionNone;
			endcase
		end
	end

	assign ramSel = region == regionRam;
	assign romSel = region == regionRom;

endmodule

//--- design/busPkg.sv
// Address map and region types on the 68000 side of the glue
package busPkg;

	// Decoded target of the current bus cycle
	typedef enum logic [1:0] {
		regionNone,
		regionRam,
		regionRom
	} regionT;

	// Windows are picked by A[23:22]
	// ROM window, always ROM
	localparam logic [1:0] RomWindow = 2'b01;

	// RAM window, shadowed by ROM while the boot overlay is set
	localparam logic [1:0] RamWindow = 2'b00;

	// Upper two windows are unmapped and decode to regionNone

endpackage

//--- design/dramPkg.sv
// DRAM sequencer states, refresh timing and DRAM address width
package dramPkg;

	// Sequencer states, encoding follows the numbering 0 to 7
	typedef enum logic [2:0] {
		stIdle      = 3'd0, // Waiting for an access or a refresh
		stRowOpen   = 3'd1, // RAS low, column goes onto RA
		stColumn    = 3'd2, // CAS low for the access
		stRefCas    = 3'd3, // CAS before RAS
		stRefRas    = 3'd4, // RAS joins CAS, refresh acknowledged
		stRefHold   = 3'd5,
		stPrecharge = 3'd6,
		stRecover   = 3'd7  // Common exit of both paths
	} ramStateT;

	// Cycles from the last refresh until a request is raised
	localparam logic [7:0] RefreshPeriod = 8'd120;

	// Count at which a pending request turns urgent
	// Has to stay above RefreshPeriod
	localparam logic [7:0] UrgentPeriod = 8'd200;

	// Width of the multiplexed DRAM address bus
	localparam int RowBits = 12;

endpackage

//--- design/glueTop.sv
`timescale 1ns/10ps

module glueTop import dramPkg::*; (
	input  logic               CLK,
	input  logic               rst,
	input  logic [23:1]        A,
	input  logic               nWE,
	input  logic               nAS,
	input  logic               nLDS,
	input  logic               nUDS,
	output logic               ramReady,
	output logic [RowBits-1:0] RA,
	output logic               nRAS,
	output logic               nCAS,
	output logic               nLWE,
	output logic               nUWE,
	output logic               nOE,
	output logic               nROMCS,
	output logic               nROMWE
);

	logic bact, ramSel, romSel;
	logic refReq, refUrg, refAck;

	// Top address bits pick the region
	busDecode decode (
		.CLK    (CLK),
		.rst    (rst),
		.nAS    (nAS),
		.A      (A[23:22]),
		.bact   (bact),
		.ramSel (ramSel),
		.romSel (romSel)
	);

	refreshTimer refresh (
		.CLK    (CLK),
		.rst    (rst),
		.refAck (refAck),
		.refReq (refReq),
		.refUrg (refUrg)
	);

	ramControl control (
		.CLK      (CLK),
		.rst      (rst),
		.A        (A[21:1]),
		.nWE      (nWE),
		.nAS      (nAS),
		.nLDS     (nLDS),
		.nUDS     (nUDS),
		.bact     (bact),
		.ramSel   (ramSel),
		.romSel   (romSel),
		.refReq   (refReq),
		.refUrg   (refUrg),
		.refAck   (refAck),
		.ramReady (ramReady),
		.RA       (RA),
		.nRAS     (nRAS),
		.nCAS     (nCAS),
		.nLWE     (nLWE),
		.nUWE     (nUWE),
		.nOE      (nOE),
		.nROMCS   (nROMCS),
		.nROMWE   (nROMWE)
	);

endmodule

//--- design/ramControl.sv
`timescale 1ns/10ps

module ramControl import dramPkg::*; (
	input  logic               CLK,
	input  logic               rst,
	input  logic [21:1]        A,
	input  logic               nWE,
	input  logic               nAS,
	input  logic               nLDS,
	input  logic               nUDS,
	input  logic               bact,
	input  logic               ramSel,
	input  logic               romSel,
	input  logic               refReq,
	input  logic               refUrg,
	output logic               refAck,
	output logic               ramReady,
	output logic [RowBits-1:0] RA,
	output logic               nRAS,
	output logic               nCAS,
	output logic               nLWE,
	output logic               nUWE,
	output logic               nOE,
	output logic               nROMCS,
	output logic               nROMWE
);

	ramStateT state, stateNext;
	logic bactR;      // bact one cycle late, finds the first cycle
	logic ramEnable;  // One DRAM access per bus cycle
	logic once;       // Access already done in this bus cycle
	logic rowSel;     // Column onto RA when set
	logic cas;        // CAS request, goes out on the falling edge
	logic rasRise;    // Row hold from the rising edge
	logic rasFall;    // Row hold from the falling edge
	logic [RowBits-1:0] rowAddr, colAddr;
	logic ramStart, refFromIdle, readyNow;

	// Row and column bit map of the board
	assign rowAddr = {A[19], A[17], A[15], A[18], A[14], A[13],
		A[12], A[11], A[19], A[16], A[10], A[9]};
	assign colAddr = {A[20], A[7], A[8], A[21], A[6], A[5],
		A[4], A[3], A[20], A[7], A[2], A[1]};
	assign RA = rowSel ? colAddr : rowAddr;

	assign ramStart = bact && ramSel && ramEnable;

	// Refresh slips in on a non-RAM cycle, or when it cannot wait
	assign refFromIdle = (refReq && bact && !bactR && !ramSel) ||
		(refUrg && !bact) ||
		(refUrg && bact && !ramEnable);

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (ramStart)
					stateNext = stRowOpen;
				else if (refFromIdle)
					stateNext = stRefCas;
			end
			stRowOpen:   stateNext = stColumn;
			stColumn:    stateNext = refUrg ? stRefCas : stRecover;
			stRefCas:    stateNext = stRefRas;
			stRefRas:    stateNext = stRefHold;
			stRefHold:   stateNext = stPrecharge;
			stPrecharge: stateNext = stRecover;
			stRecover:   stateNext = stIdle;
			default:     stateNext = stIdle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= stIdle;
			bactR <= 1'b0;
			rowSel <= 1'b0;
			cas <= 1'b0;
			rasRise <= 1'b0;
		end else begin
			state <= stateNext;
			bactR <= bact;
			rowSel <= stateNext inside {stRowOpen, stColumn};
			cas <= stateNext inside {stRowOpen, stColumn, stRefCas, stRefRas};
			rasRise <= stateNext inside {stRowOpen, stRefRas, stRefHold};
		end
	end

	// Half a cycle later than the rising edge
	always_ff @(negedge CLK) begin
		if (rst) begin
			nCAS <= 1'b1;
			rasFall <= 1'b0;
		end else begin
			nCAS <= !cas;
			rasFall <= state == stRowOpen;
		end
	end

	// Timer restarts on this pulse
	assign refAck = state == stRefRas;

	always_ff @(posedge CLK) begin
		if (rst) begin
			ramEnable <= 1'b0;
			once <= 1'b0;
		end else begin
			if (state == stIdle && refFromIdle)
				ramEnable <= 1'b0;
			else if (state == stRowOpen)
				ramEnable <= 1'b0;
			else if ((state == stIdle || state == stRecover) && (!bact || !once))
				ramEnable <= 1'b1; // Cycle over, or access still owed
			if (!bact)
				once <= 1'b0;
			else if (state == stIdle && ramStart)
				once <= 1'b1;
		end
	end

	// Ready once the owed access is done, then held until the cycle ends
	assign readyNow = (state == stRecover || (state == stIdle && !refFromIdle)) &&
		(once || !ramSel);

	always_ff @(posedge CLK) begin
		if (rst)
			ramReady <= 1'b0;
		else
			ramReady <= bact && (ramReady || readyNow);
	end

	// DRAM strobes
	assign nRAS = !((!nAS && ramSel && ramEnable) || rasRise || rasFall);
	assign nLWE = !(!nAS && !nWE && !nLDS && ramEnable);
	assign nUWE = !(!nAS && !nWE && !nUDS && ramEnable);
	assign nOE = !(!nAS && nWE); // Shared with the flash

	// Flash strobes
	assign nROMCS = !romSel;
	assign nROMWE = !(!nAS && !nWE);

endmodule

//--- design/refreshTimer.sv
`timescale 1ns/10ps

module refreshTimer import dramPkg::*; (
	input  logic CLK,
	input  logic rst,
	input  logic refAck,
	output logic refReq,
	output logic refUrg
);

	logic [7:0] refCount;

	// Counts up from the last refresh and sticks at the urgent mark
	always_ff @(posedge CLK) begin
		if (rst || refAck) begin
			refCount <= 8'd0;
		end else if (refCount != UrgentPeriod) begin
			refCount <= refCount + 8'd1;
		end
	end

	// Request first, urgent if nobody served it in time
	assign refReq = refCount >= RefreshPeriod;
	assign refUrg = refCount == UrgentPeriod;

endmodule

//--- project.f
design/busPkg.sv
design/dramPkg.sv
design/busDecode.sv
design/refreshTimer.sv
design/ramControl.sv
design/glueTop.sv
verification/glueAsserts.sv
verification/glueTb.sv

//--- verification/glueAsserts.sv
`timescale 1ns/10ps

module glueAsserts import busPkg::*; import dramPkg::*; (
	input logic               CLK,
	input logic               rst,
	input logic [23:1]        A,
	input logic               nWE,
	input logic               nAS,
	input logic               nLDS,
	input logic               nUDS,
	input logic               ramReady,
	input logic [RowBits-1:0] RA,
	input logic               nRAS,
	input logic               nCAS,
	input logic               nLWE,
	input logic               nUWE,
	input logic               nOE,
	input logic               nROMCS,
	input logic               nROMWE
);

	int failCount = 0; // Watched by the testbench
	int refGap;        // Cycles since the last CAS-before-RAS refresh
	logic romHit;      // A bus cycle reached the ROM window
	logic romSeen;     // That cycle has ended, overlay should be gone

	function automatic logic [11:0] rowOf(input logic [23:1] a);
		return {a[19], a[17], a[15], a[18], a[14], a[13],
			a[12], a[11], a[19], a[16], a[10], a[9]};
	endfunction

	function automatic logic [11:0] colOf(input logic [23:1] a);
		return {a[20], a[7], a[8], a[21], a[6], a[5],
			a[4], a[3], a[20], a[7], a[2], a[1]};
	endfunction

	always_ff @(posedge CLK) begin
		if (rst) begin
			romHit <= 1'b0;
			romSeen <= 1'b0;
			refGap <= 0;
		end else begin
			if (!nAS && !$past(nAS) && A[23:22] == RomWindow)
				romHit <= 1'b1;
			if (romHit && nAS && $past(nAS))
				romSeen <= 1'b1;
			// CAS dropping while RAS is still high starts a refresh
			refGap <= (!nCAS && $past(nCAS) && nRAS) ? 0 : refGap + 1;
		end
	end

	resetStrobes: assert property (@(posedge CLK) $fell(rst) |->
		nRAS && nCAS && nLWE && nUWE && nOE && nROMCS && nROMWE && !ramReady)
		else begin failCount++; $error("strobes active after reset"); end

	// Row on RA as RAS falls for an access
	rowAddress: assert property (@(posedge CLK) disable iff (rst)
		$fell(nRAS) && nCAS |-> RA == rowOf(A))
		else begin failCount++; $error("row address wrong"); end

	colAddress: assert property (@(posedge CLK) disable iff (rst)
		$fell(nCAS) && !nRAS |-> RA == colOf(A))
		else begin failCount++; $error("column address wrong"); end

	casBeforeRas: assert property (@(posedge CLK) disable iff (rst)
		$fell(nCAS) && nRAS |-> ##[0:2] !nRAS)
		else begin failCount++; $error("refresh RAS missing"); end

	refreshGap: assert property (@(posedge CLK) disable iff (rst)
		refGap <= int'(UrgentPeriod) + 16)
		else begin failCount++; $error("refresh interval too long"); end

	writeLanes: assert property (@(posedge CLK) disable iff (rst)
		$fell(nRAS) && nCAS && !nWE |-> nLWE == nLDS && nUWE == nUDS)
		else begin failCount++; $error("write lanes wrong"); end

	readLanes: assert property (@(posedge CLK) disable iff (rst)
		$fell(nRAS) && nCAS && nWE |-> nLWE && nUWE && !nOE)
		else begin failCount++; $error("read strobes wrong"); end

	overlayOn: assert property (@(posedge CLK) disable iff (rst)
		!nAS && A[23:22] == RamWindow && !romHit |-> !nROMCS)
		else begin failCount++; $error("overlay missing"); end

	overlayOff: assert property (@(posedge CLK) disable iff (rst)
		!nAS && A[23:22] == RamWindow && romSeen |-> nROMCS)
		else begin failCount++; $error("overlay still set"); end

	// Address zero opens a DRAM row once the overlay is gone
	overlayRam: assert property (@(posedge CLK) disable iff (rst)
		$fell(nAS) && A[23:22] == RamWindow && romSeen |-> ##[0:8] !nRAS && nCAS)
		else begin failCount++; $error("no RAM access at address zero"); end

	readyClears: assert property (@(posedge CLK) disable iff (rst)
		$past(nAS) && $past(nAS, 2) |-> !ramReady)
		else begin failCount++; $error("ramReady held"); end

endmodule

bind glueTop glueAsserts checks (.*);

//--- verification/glueTb.sv
`timescale 1ns/10ps

module glueTb;

	logic CLK, rst, nWE, nAS, nLDS, nUDS;
	logic [23:1] A;
	logic ramReady, nRAS, nCAS, nLWE, nUWE, nOE, nROMCS, nROMWE;
	logic [11:0] RA;
	logic [31:0] rngState = 32'd98196;

	glueTop UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = !CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic nextRandom(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// One CPU bus cycle, strobe held until ramReady
	task automatic busCycle(input logic [23:1] addr, input logic wr, input logic [1:0] ds);
		int waited;
		@(posedge CLK);
		#1;
		A = addr;
		nWE = !wr;
		nUDS = ds[1];
		nLDS = ds[0];
		nAS = 1'b0;
		waited = 0;
		do begin
			@(posedge CLK);
			#1;
			waited++;
			if (waited > 40) begin
				$display("Timeout waiting for ramReady at %0t", $time);
				$display("RESULT: FAIL");
				$fatal(1, "bus cycle timeout");
			end
		end while (!ramReady);
		nAS = 1'b1;
		nWE = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		idle(2);
	endtask

	// First assertion failure ends the run
	always @(negedge CLK) begin
		if (UUT.checks.failCount != 0) begin
			$display("FAILED at %0t: assertion failure in glueAsserts", $time);
			$display("RESULT: FAIL");
			$fatal(1, "assertion failed");
		end
	end

	initial begin
		logic [31:0] r, s;
		logic [1:0] ds;
		A = '0;
		nWE = 1'b1;
		nAS = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		rst = 1'b1;
		repeat (4) @(posedge CLK);
		#1;
		rst = 1'b0;
		idle(2);
		busCycle(23'h0, 1'b0, 2'b00); // Boot read through the overlay
		busCycle({2'b01, 21'h123}, 1'b0, 2'b00);
		busCycle(23'h0, 1'b1, 2'b10);
		for (int i = 0; i < 80; i++) begin
			nextRandom(r);
			nextRandom(s);
			ds = (s[1:0] == 2'b11) ? 2'b00 : s[1:0]; // At least one lane
			if (s[4:2] == 0)
				busCycle(r[22:0], s[5], ds);
			else
				busCycle({2'b00, r[20:0]}, s[5], ds);
			if (s[10:8] == 0)
				idle(250); // Urgent refresh
			else
				idle(int'(s[13:11]));
		end
		idle(4);
		if (UUT.checks.failCount == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule
